// ==== hdl/issue_pkg.sv ====
package issue_pkg;

    // data and address width
    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    // rv32i major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_arith  = 7'b0110011;
    localparam logic [6:0] op_arithi = 7'b0010011;

    // kind of entry allocated in the reorder buffer
    typedef enum logic [1:0] {
        rob_reg  = 2'd0,
        rob_regi = 2'd1,
        rob_br   = 2'd2,
        rob_st   = 2'd3
    } rob_kind_t;

    // {branch, funct3, alt}
    typedef logic [4:0] rs_op_t;

    // {store, funct3}
    typedef logic [3:0] lsb_op_t;

    // one-hot instruction class, all zero for an unknown opcode
    typedef struct packed {
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic arith;
        logic arithi;
    } inst_class_t;

endpackage

// ==== hdl/operand_resolver.sv ====
`timescale 1ns/1ps

module operand_resolver #(
    parameter int rob_idx_width = 4
) (
    input  logic                       used,
    input  logic [issue_pkg::xlen-1:0] rf_val,
    input  logic                       rf_has_dep,
    input  logic [rob_idx_width-1:0]   rf_dep,
    input  logic                       rob_done,
    input  logic [issue_pkg::xlen-1:0] rob_val,
    output logic [rob_idx_width-1:0]   rob_qry_idx,
    output logic [issue_pkg::xlen-1:0] val,
    output logic                       has_dep,
    output logic [rob_idx_width-1:0]   dep
);

    // the rob is always asked about the register file's tag
    assign rob_qry_idx = rf_dep;

    always_comb begin
        if (!rf_has_dep) begin
            val     = rf_val;
            has_dep = 1'b0;
            dep     = '0;
        end else if (rob_done) begin
            // producer finished, take the result and drop the tag
            val     = rob_val;
            has_dep = 1'b0;
            dep     = '0;
        end else begin
            val     = '0;
            has_dep = used;
            dep     = rf_dep;
        end
    end

    // a pending operand never carries a value
    always_comb begin
        if (has_dep) begin
            assert (val == '0)
                else $error("operand_resolver: pending operand has nonzero value");
        end
    end

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic [issue_pkg::xlen-1:0] inst,
    input  logic [issue_pkg::xlen-1:0] inst_addr,
    output issue_pkg::inst_class_t     inst_class,
    output issue_pkg::reg_idx_t        rs1_idx,
    output issue_pkg::reg_idx_t        rs2_idx,
    output issue_pkg::reg_idx_t        rd,
    output logic                       rs2_used,
    output logic [issue_pkg::xlen-1:0] imm,
    output issue_pkg::rs_op_t          rs_op,
    output issue_pkg::lsb_op_t         lsb_op,
    output issue_pkg::rob_kind_t       rob_kind,
    output logic                       rob_done,
    output logic [issue_pkg::xlen-1:0] rob_value
);

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic                       is_shift;
    logic                       alt;
    logic [issue_pkg::xlen-1:0] imm_i;
    logic [issue_pkg::xlen-1:0] imm_sh;
    logic [issue_pkg::xlen-1:0] imm_s;
    logic [issue_pkg::xlen-1:0] imm_b;
    logic [issue_pkg::xlen-1:0] imm_u;
    logic [issue_pkg::xlen-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        inst_class = '0;
        case (opcode)
            issue_pkg::op_lui:    inst_class.lui    = 1'b1;
            issue_pkg::op_auipc:  inst_class.auipc  = 1'b1;
            issue_pkg::op_jal:    inst_class.jal    = 1'b1;
            issue_pkg::op_jalr:   inst_class.jalr   = 1'b1;
            issue_pkg::op_branch: inst_class.branch = 1'b1;
            issue_pkg::op_load:   inst_class.load   = 1'b1;
            issue_pkg::op_store:  inst_class.store  = 1'b1;
            issue_pkg::op_arith:  inst_class.arith  = 1'b1;
            issue_pkg::op_arithi: inst_class.arithi = 1'b1;
            default: ;
        endcase
    end

    // slli, srli and srai
    assign is_shift = inst_class.arithi && (funct3[1:0] == 2'b01);

    // immediate formats, sign extended
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_sh = {27'b0, inst[24:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u  = {inst[31:12], 12'b0};
    assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (1'b1)
            inst_class.arithi:                 imm = is_shift ? imm_sh : imm_i;
            inst_class.load, inst_class.jalr:  imm = imm_i;
            inst_class.store:                  imm = imm_s;
            inst_class.branch:                 imm = imm_b;
            inst_class.lui, inst_class.auipc:  imm = imm_u;
            inst_class.jal:                    imm = imm_j;
            default:                           imm = '0;
        endcase
    end

    assign rs1_idx  = inst[19:15];
    assign rs2_idx  = inst[24:20];
    assign rs2_used = inst_class.arith || inst_class.branch || inst_class.store;

    // branch rd holds the taken prediction
    always_comb begin
        if (inst_class.store) begin
            rd = 5'd0;
        end else if (inst_class.branch) begin
            rd = 5'd1;
        end else begin
            rd = inst[11:7];
        end
    end

    // funct7[5] only matters for arith and immediate shifts
    assign alt    = (inst_class.branch || (inst_class.arithi && !is_shift)) ? 1'b0 : inst[30];
    assign rs_op  = {inst_class.branch, funct3, alt};
    assign lsb_op = {inst_class.store, funct3};

    always_comb begin
        if (inst_class.arithi) begin
            rob_kind = issue_pkg::rob_regi;
        end else if (inst_class.branch) begin
            rob_kind = issue_pkg::rob_br;
        end else if (inst_class.store) begin
            rob_kind = issue_pkg::rob_st;
        end else begin
            rob_kind = issue_pkg::rob_reg;
        end
    end

    // these four finish at issue
    assign rob_done = inst_class.lui || inst_class.auipc || inst_class.jal || inst_class.jalr;

    always_comb begin
        if (inst_class.lui) begin
            rob_value = imm_u;
        end else if (inst_class.auipc) begin
            rob_value = inst_addr + imm_u;
        end else begin
            rob_value = inst_addr + 32'd4;
        end
    end

    always_comb begin
        assert ($onehot0(inst_class))
            else $error("inst_decoder: class is not one-hot");
    end

endmodule

// ==== hdl/next_pc_unit.sv ====
`timescale 1ns/1ps

module next_pc_unit (
    input  logic                       inst_valid,
    input  logic [issue_pkg::xlen-1:0] inst_addr,
    input  issue_pkg::inst_class_t     inst_class,
    input  logic [issue_pkg::xlen-1:0] imm,
    input  logic [issue_pkg::xlen-1:0] r1_val,
    input  logic                       r1_has_dep,
    input  logic                       rob_full,
    input  logic                       rob_clear,
    input  logic                       rs_full,
    input  logic                       lsb_full,
    output logic [issue_pkg::xlen-1:0] next_pc,
    output logic                       stall
);

    // branches are always predicted taken
    always_comb begin
        if (inst_class.jal || inst_class.branch) begin
            next_pc = inst_addr + imm;
        end else if (inst_class.jalr) begin
            next_pc = r1_val + imm;
        end else begin
            next_pc = inst_addr + 32'd4;
        end
    end

    // jalr cannot redirect fetch until its base is known
    assign stall = !inst_valid
                || rob_clear
                || rob_full
                || rs_full
                || lsb_full
                || (inst_class.jalr && r1_has_dep);

endmodule

// ==== hdl/issue_register.sv ====
`timescale 1ns/1ps

module issue_register #(
    parameter int rob_idx_width = 4
) (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       rdy_in,
    input  logic                       stall,
    input  logic                       rob_clear,
    input  logic [issue_pkg::xlen-1:0] inst_addr,
    input  issue_pkg::inst_class_t     inst_class,
    input  issue_pkg::reg_idx_t        dec_rd,
    input  logic [issue_pkg::xlen-1:0] dec_imm,
    input  issue_pkg::rs_op_t          dec_rs_op,
    input  issue_pkg::lsb_op_t         dec_lsb_op,
    input  issue_pkg::rob_kind_t       dec_rob_kind,
    input  logic                       dec_rob_done,
    input  logic [issue_pkg::xlen-1:0] dec_rob_value,
    input  logic [rob_idx_width-1:0]   rob_vacant,
    input  logic [issue_pkg::xlen-1:0] opd1_val,
    input  logic                       opd1_has_dep,
    input  logic [rob_idx_width-1:0]   opd1_dep,
    input  logic [issue_pkg::xlen-1:0] opd2_val,
    input  logic                       opd2_has_dep,
    input  logic [rob_idx_width-1:0]   opd2_dep,
    output logic                       rob_push,
    output logic                       rob_done,
    output logic [issue_pkg::xlen-1:0] rob_value,
    output logic [issue_pkg::xlen-1:0] rob_addr,
    output issue_pkg::rob_kind_t       rob_kind,
    output issue_pkg::reg_idx_t        rob_rd,
    output logic                       rs_push,
    output issue_pkg::rs_op_t          rs_op,
    output logic                       lsb_push,
    output issue_pkg::lsb_op_t         lsb_op,
    output logic [issue_pkg::xlen-1:0] r1_val,
    output logic [issue_pkg::xlen-1:0] r2_val,
    output logic                       r1_has_dep,
    output logic                       r2_has_dep,
    output logic [rob_idx_width-1:0]   r1_dep,
    output logic [rob_idx_width-1:0]   r2_dep,
    output logic [rob_idx_width-1:0]   entry_rob,
    output logic [issue_pkg::xlen-1:0] imm
);

    logic accept;
    logic to_rs;
    logic to_lsb;

    // qualified by rdy_in at the registers
    assign accept = !stall && !rob_clear;
    assign to_rs  = inst_class.arith || inst_class.arithi || inst_class.branch;
    assign to_lsb = inst_class.load || inst_class.store;

    // strobes and operands, zeroed on stall or clear
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            rob_push   <= 1'b0;
            rs_push    <= 1'b0;
            lsb_push   <= 1'b0;
            r1_val     <= '0;
            r2_val     <= '0;
            r1_has_dep <= 1'b0;
            r2_has_dep <= 1'b0;
            r1_dep     <= '0;
            r2_dep     <= '0;
            entry_rob  <= '0;
        end else if (rdy_in) begin
            rob_push   <= accept;
            rs_push    <= accept && to_rs;
            lsb_push   <= accept && to_lsb;
            r1_val     <= accept ? opd1_val : '0;
            // arithi carries its immediate as the second operand
            r2_val     <= !accept ? '0 : (inst_class.arithi ? dec_imm : opd2_val);
            r1_has_dep <= accept && opd1_has_dep;
            r2_has_dep <= accept && opd2_has_dep;
            r1_dep     <= accept ? opd1_dep : '0;
            r2_dep     <= accept ? opd2_dep : '0;
            entry_rob  <= accept ? rob_vacant : '0;
        end
    end

    // payload, only meaningful under a push strobe
    always_ff @(posedge clk_in) begin
        if (rdy_in && accept) begin
            rob_done  <= dec_rob_done;
            rob_value <= dec_rob_value;
            rob_kind  <= dec_rob_kind;
            rob_rd    <= dec_rd;
            rs_op     <= dec_rs_op;
            lsb_op    <= dec_lsb_op;
            imm       <= dec_imm;
            if (inst_class.branch) begin
                // fall-through for a mispredicted taken branch
                rob_addr <= inst_addr + 32'd4;
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in) !(rs_push && lsb_push))
        else $error("issue_register: rs and lsb pushed together");

endmodule

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage #(
    parameter int rob_idx_width = 4
) (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       rdy_in,
    // fetch
    input  logic                       inst_valid,
    input  logic [issue_pkg::xlen-1:0] inst,
    input  logic [issue_pkg::xlen-1:0] inst_addr,
    output logic                       stall,
    output logic [issue_pkg::xlen-1:0] next_pc,
    // register file
    output issue_pkg::reg_idx_t        rs1_idx,
    output issue_pkg::reg_idx_t        rs2_idx,
    input  logic [issue_pkg::xlen-1:0] rs1_val,
    input  logic                       rs1_has_dep,
    input  logic [rob_idx_width-1:0]   rs1_dep,
    input  logic [issue_pkg::xlen-1:0] rs2_val,
    input  logic                       rs2_has_dep,
    input  logic [rob_idx_width-1:0]   rs2_dep,
    // rob query
    output logic [rob_idx_width-1:0]   rob_qry1_idx,
    input  logic                       rob_qry1_done,
    input  logic [issue_pkg::xlen-1:0] rob_qry1_val,
    output logic [rob_idx_width-1:0]   rob_qry2_idx,
    input  logic                       rob_qry2_done,
    input  logic [issue_pkg::xlen-1:0] rob_qry2_val,
    // rob allocation
    input  logic                       rob_full,
    input  logic                       rob_clear,
    input  logic [rob_idx_width-1:0]   rob_vacant,
    output logic                       rob_push,
    output logic                       rob_done,
    output logic [issue_pkg::xlen-1:0] rob_value,
    output logic [issue_pkg::xlen-1:0] rob_addr,
    output issue_pkg::rob_kind_t       rob_kind,
    output issue_pkg::reg_idx_t        rob_rd,
    // rs and lsb
    input  logic                       rs_full,
    output logic                       rs_push,
    output issue_pkg::rs_op_t          rs_op,
    input  logic                       lsb_full,
    output logic                       lsb_push,
    output issue_pkg::lsb_op_t         lsb_op,
    output logic [issue_pkg::xlen-1:0] r1_val,
    output logic [issue_pkg::xlen-1:0] r2_val,
    output logic                       r1_has_dep,
    output logic                       r2_has_dep,
    output logic [rob_idx_width-1:0]   r1_dep,
    output logic [rob_idx_width-1:0]   r2_dep,
    output logic [rob_idx_width-1:0]   entry_rob,
    output logic [issue_pkg::xlen-1:0] imm
);

    issue_pkg::inst_class_t     dec_class;
    issue_pkg::reg_idx_t        dec_rd;
    logic                       dec_rs2_used;
    logic [issue_pkg::xlen-1:0] dec_imm;
    issue_pkg::rs_op_t          dec_rs_op;
    issue_pkg::lsb_op_t         dec_lsb_op;
    issue_pkg::rob_kind_t       dec_rob_kind;
    logic                       dec_rob_done;
    logic [issue_pkg::xlen-1:0] dec_rob_value;
    logic [issue_pkg::xlen-1:0] opd1_val;
    logic                       opd1_has_dep;
    logic [rob_idx_width-1:0]   opd1_dep;
    logic [issue_pkg::xlen-1:0] opd2_val;
    logic                       opd2_has_dep;
    logic [rob_idx_width-1:0]   opd2_dep;

    inst_decoder u_decoder (
        .inst       (inst),
        .inst_addr  (inst_addr),
        .inst_class (dec_class),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rd         (dec_rd),
        .rs2_used   (dec_rs2_used),
        .imm        (dec_imm),
        .rs_op      (dec_rs_op),
        .lsb_op     (dec_lsb_op),
        .rob_kind   (dec_rob_kind),
        .rob_done   (dec_rob_done),
        .rob_value  (dec_rob_value)
    );

    // rs1 is treated as always read
    operand_resolver #(.rob_idx_width(rob_idx_width)) u_opd1 (
        .used        (1'b1),
        .rf_val      (rs1_val),
        .rf_has_dep  (rs1_has_dep),
        .rf_dep      (rs1_dep),
        .rob_done    (rob_qry1_done),
        .rob_val     (rob_qry1_val),
        .rob_qry_idx (rob_qry1_idx),
        .val         (opd1_val),
        .has_dep     (opd1_has_dep),
        .dep         (opd1_dep)
    );

    operand_resolver #(.rob_idx_width(rob_idx_width)) u_opd2 (
        .used        (dec_rs2_used),
        .rf_val      (rs2_val),
        .rf_has_dep  (rs2_has_dep),
        .rf_dep      (rs2_dep),
        .rob_done    (rob_qry2_done),
        .rob_val     (rob_qry2_val),
        .rob_qry_idx (rob_qry2_idx),
        .val         (opd2_val),
        .has_dep     (opd2_has_dep),
        .dep         (opd2_dep)
    );

    next_pc_unit u_next_pc (
        .inst_valid (inst_valid),
        .inst_addr  (inst_addr),
        .inst_class (dec_class),
        .imm        (dec_imm),
        .r1_val     (opd1_val),
        .r1_has_dep (opd1_has_dep),
        .rob_full   (rob_full),
        .rob_clear  (rob_clear),
        .rs_full    (rs_full),
        .lsb_full   (lsb_full),
        .next_pc    (next_pc),
        .stall      (stall)
    );

    issue_register #(.rob_idx_width(rob_idx_width)) u_issue (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .rdy_in        (rdy_in),
        .stall         (stall),
        .rob_clear     (rob_clear),
        .inst_addr     (inst_addr),
        .inst_class    (dec_class),
        .dec_rd        (dec_rd),
        .dec_imm       (dec_imm),
        .dec_rs_op     (dec_rs_op),
        .dec_lsb_op    (dec_lsb_op),
        .dec_rob_kind  (dec_rob_kind),
        .dec_rob_done  (dec_rob_done),
        .dec_rob_value (dec_rob_value),
        .rob_vacant    (rob_vacant),
        .opd1_val      (opd1_val),
        .opd1_has_dep  (opd1_has_dep),
        .opd1_dep      (opd1_dep),
        .opd2_val      (opd2_val),
        .opd2_has_dep  (opd2_has_dep),
        .opd2_dep      (opd2_dep),
        .rob_push      (rob_push),
        .rob_done      (rob_done),
        .rob_value     (rob_value),
        .rob_addr      (rob_addr),
        .rob_kind      (rob_kind),
        .rob_rd        (rob_rd),
        .rs_push       (rs_push),
        .rs_op         (rs_op),
        .lsb_push      (lsb_push),
        .lsb_op        (lsb_op),
        .r1_val        (r1_val),
        .r2_val        (r2_val),
        .r1_has_dep    (r1_has_dep),
        .r2_has_dep    (r2_has_dep),
        .r1_dep        (r1_dep),
        .r2_dep        (r2_dep),
        .entry_rob     (entry_rob),
        .imm           (imm)
    );

endmodule

// ==== test/issue_cases.svh ====
`ifndef issue_cases_svh
`define issue_cases_svh

// src: 0 register file, 1 finished rob producer, 2 pending producer
// cond: {invalid, rob_clear, rob_full, rs_full, lsb_full}
// push: {rob, rs, lsb}; op holds rs_op, or lsb_op in the low 4 bits
// pc_rel set means next_pc is the resolved rs1 value plus the next_pc column
// rs1 and rs2 give the register file indices read by the instruction
typedef struct packed {
    logic [31:0]          inst;
    logic [31:0]          addr;
    logic [1:0]           src1;
    logic [1:0]           src2;
    logic [4:0]           cond;
    logic                 stall;
    logic                 pc_rel;
    logic [31:0]          next_pc;
    logic [2:0]           push;
    logic                 done;
    logic [31:0]          value;
    issue_pkg::rob_kind_t kind;
    logic [4:0]           rd;
    logic [31:0]          imm;
    logic [4:0]           op;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
} case_row_t;

localparam int num_cases = 20;

localparam case_row_t cases [num_cases] = '{
    // add x3, x1, x2
    '{32'h002081b3, 32'h00001000, 2'd0, 2'd0, 5'b00000, 1'b0, 1'b0, 32'h00001004,
      3'b110, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd3, 32'h0, 5'h00, 5'd1, 5'd2},
    // sub x5, x6, x7 with rs1 forwarded and rs2 pending
    '{32'h407302b3, 32'h00001004, 2'd1, 2'd2, 5'b00000, 1'b0, 1'b0, 32'h00001008,
      3'b110, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd5, 32'h0, 5'h01, 5'd6, 5'd7},
    // addi x4, x1, -5
    '{32'hffb08213, 32'h00001008, 2'd0, 2'd2, 5'b00000, 1'b0, 1'b0, 32'h0000100c,
      3'b110, 1'b0, 32'h0, issue_pkg::rob_regi, 5'd4, 32'hfffffffb, 5'h00, 5'd1, 5'd27},
    // srai x6, x2, 3
    '{32'h40315313, 32'h0000100c, 2'd2, 2'd0, 5'b00000, 1'b0, 1'b0, 32'h00001010,
      3'b110, 1'b0, 32'h0, issue_pkg::rob_regi, 5'd6, 32'h3, 5'h0b, 5'd2, 5'd3},
    // lw x7, -8(x3)
    '{32'hff81a383, 32'h00001010, 2'd1, 2'd0, 5'b00000, 1'b0, 1'b0, 32'h00001014,
      3'b101, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd7, 32'hfffffff8, 5'h02, 5'd3, 5'd24},
    // sw x9, 20(x4)
    '{32'h00922a23, 32'h00001014, 2'd0, 2'd2, 5'b00000, 1'b0, 1'b0, 32'h00001018,
      3'b101, 1'b0, 32'h0, issue_pkg::rob_st, 5'd0, 32'h14, 5'h0a, 5'd4, 5'd9},
    // lui x10, 0x12345
    '{32'h12345537, 32'h00001018, 2'd0, 2'd0, 5'b00000, 1'b0, 1'b0, 32'h0000101c,
      3'b100, 1'b1, 32'h12345000, issue_pkg::rob_reg, 5'd10, 32'h12345000, 5'h00,
      5'd8, 5'd3},
    // auipc x11, 0xfffff wraps around
    '{32'hfffff597, 32'h00002000, 2'd0, 2'd0, 5'b00000, 1'b0, 1'b0, 32'h00002004,
      3'b100, 1'b1, 32'h00001000, issue_pkg::rob_reg, 5'd11, 32'hfffff000, 5'h00,
      5'd31, 5'd31},
    // jal x1, -16
    '{32'hff1ff0ef, 32'h00003000, 2'd0, 2'd0, 5'b00000, 1'b0, 1'b0, 32'h00002ff0,
      3'b100, 1'b1, 32'h00003004, issue_pkg::rob_reg, 5'd1, 32'hfffffff0, 5'h00,
      5'd31, 5'd17},
    // jalr x5, 12(x6) from the register file, then from the rob, then pending
    '{32'h00c302e7, 32'h00003010, 2'd0, 2'd0, 5'b00000, 1'b0, 1'b1, 32'h0000000c,
      3'b100, 1'b1, 32'h00003014, issue_pkg::rob_reg, 5'd5, 32'hc, 5'h00, 5'd6, 5'd12},
    '{32'h00c302e7, 32'h00003020, 2'd1, 2'd0, 5'b00000, 1'b0, 1'b1, 32'h0000000c,
      3'b100, 1'b1, 32'h00003024, issue_pkg::rob_reg, 5'd5, 32'hc, 5'h00, 5'd6, 5'd12},
    '{32'h00c302e7, 32'h00003030, 2'd2, 2'd0, 5'b00000, 1'b1, 1'b1, 32'h0000000c,
      3'b000, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd0, 32'h0, 5'h00, 5'd6, 5'd12},
    // beq x1, x2, +8
    '{32'h00208463, 32'h00004000, 2'd0, 2'd1, 5'b00000, 1'b0, 1'b0, 32'h00004008,
      3'b110, 1'b0, 32'h0, issue_pkg::rob_br, 5'd1, 32'h8, 5'h10, 5'd1, 5'd2},
    // bne x3, x4, -4 has bit 30 set
    '{32'hfe419ee3, 32'h00004010, 2'd2, 2'd2, 5'b00000, 1'b0, 1'b0, 32'h0000400c,
      3'b110, 1'b0, 32'h0, issue_pkg::rob_br, 5'd1, 32'hfffffffc, 5'h12, 5'd3, 5'd4},
    // back-pressure, clear and invalid fetch
    '{32'h002081b3, 32'h00005000, 2'd0, 2'd0, 5'b00100, 1'b1, 1'b0, 32'h00005004,
      3'b000, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd0, 32'h0, 5'h00, 5'd1, 5'd2},
    '{32'h00922a23, 32'h00005004, 2'd0, 2'd0, 5'b00001, 1'b1, 1'b0, 32'h00005008,
      3'b000, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd0, 32'h0, 5'h00, 5'd4, 5'd9},
    '{32'hffb08213, 32'h00005008, 2'd0, 2'd0, 5'b00010, 1'b1, 1'b0, 32'h0000500c,
      3'b000, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd0, 32'h0, 5'h00, 5'd1, 5'd27},
    '{32'h12345537, 32'h0000500c, 2'd0, 2'd0, 5'b01000, 1'b1, 1'b0, 32'h00005010,
      3'b000, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd0, 32'h0, 5'h00, 5'd8, 5'd3},
    '{32'h002081b3, 32'h00005010, 2'd0, 2'd0, 5'b10000, 1'b1, 1'b0, 32'h00005014,
      3'b000, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd0, 32'h0, 5'h00, 5'd1, 5'd2},
    // lbu x2, 0x7ff(x1), rs2 pending but unused
    '{32'h7ff0c103, 32'h00006000, 2'd1, 2'd2, 5'b00000, 1'b0, 1'b0, 32'h00006004,
      3'b101, 1'b0, 32'h0, issue_pkg::rob_reg, 5'd2, 32'h7ff, 5'h04, 5'd1, 5'd31}
};

`endif

// ==== test/tb_issue_stage.sv ====
`timescale 1ns/1ps

module tb_issue_stage;

    localparam int rob_idx_width = 4;
    localparam int clk_period    = 10;
    localparam int reset_cycles  = 8;

    logic                     clk_in;
    logic                     rst_in;
    logic                     rdy_in;
    logic                     inst_valid;
    logic [31:0]              inst;
    logic [31:0]              inst_addr;
    logic                     stall;
    logic [31:0]              next_pc;
    logic [4:0]               rs1_idx;
    logic [4:0]               rs2_idx;
    logic [31:0]              rs1_val;
    logic                     rs1_has_dep;
    logic [rob_idx_width-1:0] rs1_dep;
    logic [31:0]              rs2_val;
    logic                     rs2_has_dep;
    logic [rob_idx_width-1:0] rs2_dep;
    logic [rob_idx_width-1:0] rob_qry1_idx;
    logic                     rob_qry1_done;
    logic [31:0]              rob_qry1_val;
    logic [rob_idx_width-1:0] rob_qry2_idx;
    logic                     rob_qry2_done;
    logic [31:0]              rob_qry2_val;
    logic                     rob_full;
    logic                     rob_clear;
    logic [rob_idx_width-1:0] rob_vacant;
    logic                     rob_push;
    logic                     rob_done;
    logic [31:0]              rob_value;
    logic [31:0]              rob_addr;
    logic [1:0]               rob_kind;
    logic [4:0]               rob_rd;
    logic                     rs_full;
    logic                     rs_push;
    logic [4:0]               rs_op;
    logic                     lsb_full;
    logic                     lsb_push;
    logic [3:0]               lsb_op;
    logic [31:0]              r1_val;
    logic [31:0]              r2_val;
    logic                     r1_has_dep;
    logic                     r2_has_dep;
    logic [rob_idx_width-1:0] r1_dep;
    logic [rob_idx_width-1:0] r2_dep;
    logic [rob_idx_width-1:0] entry_rob;
    logic [31:0]              imm;

    `include "issue_cases.svh"

    int                       errors;
    int                       row_num;
    logic [31:0]              exp_next_pc;
    logic [31:0]              exp_r1_val;
    logic [31:0]              exp_r2_val;
    logic                     exp_r1_has_dep;
    logic                     exp_r2_has_dep;
    logic [rob_idx_width-1:0] exp_r1_dep;
    logic [rob_idx_width-1:0] exp_r2_dep;
    logic [rob_idx_width-1:0] exp_entry;

    issue_stage #(.rob_idx_width(rob_idx_width)) uut (.*);

    always #(clk_period / 2) clk_in = ~clk_in;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("[FAIL] row %0d %s: expected %h, actual %h",
                     row_num, name, expected, actual);
        end
    endtask

    // drive one row and work out the operands it should resolve to
    task automatic apply_row(input case_row_t row);
        logic [31:0] rf1;
        logic [31:0] rf2;
        logic [31:0] rob1;
        logic [31:0] rob2;
        logic        rs2_read;
        rf1  = $urandom;
        rf2  = $urandom;
        rob1 = $urandom;
        rob2 = $urandom;
        inst          = row.inst;
        inst_addr     = row.addr;
        inst_valid    = !row.cond[4];
        rob_clear     = row.cond[3];
        rob_full      = row.cond[2];
        rs_full       = row.cond[1];
        lsb_full      = row.cond[0];
        rs1_val       = rf1;
        rs1_has_dep   = (row.src1 != 2'd0);
        rs1_dep       = rob_idx_width'($urandom);
        rob_qry1_done = (row.src1 == 2'd1);
        rob_qry1_val  = rob1;
        rs2_val       = rf2;
        rs2_has_dep   = (row.src2 != 2'd0);
        rs2_dep       = rob_idx_width'($urandom);
        rob_qry2_done = (row.src2 == 2'd1);
        rob_qry2_val  = rob2;
        rob_vacant    = rob_idx_width'($urandom);

        // arith, branch and store read rs2
        rs2_read = (row.kind == issue_pkg::rob_st) || (row.kind == issue_pkg::rob_br)
                || (row.kind == issue_pkg::rob_reg && row.push[1]);
        exp_r1_val     = (row.src1 == 2'd0) ? rf1 : ((row.src1 == 2'd1) ? rob1 : 32'h0);
        exp_r1_has_dep = (row.src1 == 2'd2);
        exp_r1_dep     = (row.src1 == 2'd2) ? rs1_dep : '0;
        exp_r2_val     = (row.src2 == 2'd0) ? rf2 : ((row.src2 == 2'd1) ? rob2 : 32'h0);
        exp_r2_has_dep = (row.src2 == 2'd2) && rs2_read;
        exp_r2_dep     = (row.src2 == 2'd2) ? rs2_dep : '0;
        exp_entry      = rob_vacant;
        if (row.kind == issue_pkg::rob_regi) begin
            exp_r2_val = row.imm;
        end
        exp_next_pc = row.pc_rel ? exp_r1_val + row.next_pc : row.next_pc;

        // a stalled edge clears the operand registers
        if (row.stall) begin
            exp_r1_val     = 32'h0;
            exp_r2_val     = 32'h0;
            exp_r1_has_dep = 1'b0;
            exp_r2_has_dep = 1'b0;
            exp_r1_dep     = '0;
            exp_r2_dep     = '0;
            exp_entry      = '0;
        end
    endtask

    task automatic confirm_prediction(input case_row_t row);
        compare_field("stall", 32'(row.stall), 32'(stall));
        compare_field("next_pc", exp_next_pc, next_pc);
        compare_field("rs1_idx", 32'(row.rs1), 32'(rs1_idx));
        compare_field("rs2_idx", 32'(row.rs2), 32'(rs2_idx));
        compare_field("rob_qry1_idx", 32'(rs1_dep), 32'(rob_qry1_idx));
        compare_field("rob_qry2_idx", 32'(rs2_dep), 32'(rob_qry2_idx));
    endtask

    task automatic review_issue(input case_row_t row);
        compare_field("rob_push", 32'(row.push[2]), 32'(rob_push));
        compare_field("rs_push", 32'(row.push[1]), 32'(rs_push));
        compare_field("lsb_push", 32'(row.push[0]), 32'(lsb_push));
        compare_field("r1_val", exp_r1_val, r1_val);
        compare_field("r2_val", exp_r2_val, r2_val);
        compare_field("r1_has_dep", 32'(exp_r1_has_dep), 32'(r1_has_dep));
        compare_field("r2_has_dep", 32'(exp_r2_has_dep), 32'(r2_has_dep));
        compare_field("r1_dep", 32'(exp_r1_dep), 32'(r1_dep));
        compare_field("r2_dep", 32'(exp_r2_dep), 32'(r2_dep));
        compare_field("entry_rob", 32'(exp_entry), 32'(entry_rob));
        if (row.push[2]) begin
            compare_field("rob_done", 32'(row.done), 32'(rob_done));
            compare_field("rob_kind", 32'(row.kind), 32'(rob_kind));
            compare_field("rob_rd", 32'(row.rd), 32'(rob_rd));
            compare_field("imm", row.imm, imm);
            if (row.done) begin
                compare_field("rob_value", row.value, rob_value);
            end
            // fall-through address of a taken prediction
            if (row.kind == issue_pkg::rob_br) begin
                compare_field("rob_addr", row.addr + 32'd4, rob_addr);
            end
        end
        if (row.push[1]) begin
            compare_field("rs_op", 32'(row.op), 32'(rs_op));
        end
        if (row.push[0]) begin
            compare_field("lsb_op", 32'(row.op[3:0]), 32'(lsb_op));
        end
    endtask

    initial begin
        void'($urandom(75));
        errors        = 0;
        row_num       = 0;
        clk_in        = 1'b0;
        rst_in        = 1'b1;
        rdy_in        = 1'b1;
        inst_valid    = 1'b0;
        inst          = 32'h0;
        inst_addr     = 32'h0;
        rs1_val       = 32'h0;
        rs1_has_dep   = 1'b0;
        rs1_dep       = '0;
        rs2_val       = 32'h0;
        rs2_has_dep   = 1'b0;
        rs2_dep       = '0;
        rob_qry1_done = 1'b0;
        rob_qry1_val  = 32'h0;
        rob_qry2_done = 1'b0;
        rob_qry2_val  = 32'h0;
        rob_full      = 1'b0;
        rob_clear     = 1'b0;
        rob_vacant    = '0;
        rs_full       = 1'b0;
        lsb_full      = 1'b0;

        repeat (reset_cycles) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        if (rob_push !== 1'b0) begin
            errors = errors + 1;
            $display("[FAIL] after reset rob_push: expected 0, actual %h", rob_push);
        end
        if (rs_push !== 1'b0) begin
            errors = errors + 1;
            $display("[FAIL] after reset rs_push: expected 0, actual %h", rs_push);
        end
        if (lsb_push !== 1'b0) begin
            errors = errors + 1;
            $display("[FAIL] after reset lsb_push: expected 0, actual %h", lsb_push);
        end

        for (int i = 0; i < num_cases; i++) begin
            row_num = i;
            apply_row(cases[i]);
            #1;
            confirm_prediction(cases[i]);
            @(posedge clk_in);
            @(negedge clk_in);
            review_issue(cases[i]);
        end

        $display("%0d rows run, %0d errors", num_cases, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((num_cases * 4 + reset_cycles + 20) * clk_period);
        $display("timeout, the table did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+test
hdl/issue_pkg.sv
hdl/operand_resolver.sv
hdl/inst_decoder.sv
hdl/next_pc_unit.sv
hdl/issue_register.sv
hdl/issue_stage.sv
test/tb_issue_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -j 0 --assert --timescale 1ns/1ps \
    --top-module tb_issue_stage -f build.f -o sim_issue \
    && ./obj_dir/sim_issue > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
